// File: common/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path and address width
`define XLEN 32

// register file index width, 32 registers
`define REG_ADDR_W 5

// return-address stack entries
// kept small so overflow shows up in short programs
`define RAS_DEPTH 4

// byte step between sequential instructions
`define INSTR_BYTES 4

`endif

// File: common/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    // alu selection, decode to execute
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        PASS_B = 3'd5
    } alu_op_t;

    //////////////////////////////////////////////////
    // instruction field helpers
    //////////////////////////////////////////////////

    function automatic reg_addr_t get_rd(input word_t ins);
        return ins[11:7];
    endfunction

    function automatic reg_addr_t get_rs1(input word_t ins);
        return ins[19:15];
    endfunction

    function automatic reg_addr_t get_rs2(input word_t ins);
        return ins[24:20];
    endfunction

    function automatic logic [2:0] get_funct3(input word_t ins);
        return ins[14:12];
    endfunction

    function automatic logic [6:0] get_funct7(input word_t ins);
        return ins[31:25];
    endfunction

endpackage

// File: design/core/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  word_t     ins,
    input  logic      if_valid,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output alu_op_t   alu_op,
    output word_t     imm,
    output logic      use_imm,
    output logic      regwrite,
    output logic      is_jal,
    output logic      is_jalr,
    output logic      is_lui
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    // known encoding, writes a register
    logic       writes;

    // register indices come straight from the word
    assign rs1    = get_rs1(ins);
    assign rs2    = get_rs2(ins);
    assign rd     = get_rd(ins);
    assign funct3 = get_funct3(ins);
    assign funct7 = get_funct7(ins);

    //////////////////////////////////////////////////
    // control decode
    //////////////////////////////////////////////////

    always_comb begin
        alu_op  = ADD;
        imm     = '0;
        use_imm = 1'b0;
        writes  = 1'b0;
        is_jal  = 1'b0;
        is_jalr = 1'b0;
        is_lui  = 1'b0;

        case (opcode_t'(ins[6:0]))
            OP: begin
                // register-register alu ops
                writes = 1'b1;
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0100000) begin
                            alu_op = SUB;
                        end else if (funct7 == 7'b0000000) begin
                            alu_op = ADD;
                        end else begin
                            writes = 1'b0;
                        end
                    end
                    3'b100: alu_op = XOR;
                    3'b110: alu_op = OR;
                    3'b111: alu_op = AND;
                    default: writes = 1'b0;
                endcase
                // only funct7 of zero is legal outside add/sub
                if (funct3 != 3'b000 && funct7 != 7'b0000000) begin
                    writes = 1'b0;
                end
            end
            OP_IMM: begin
                // addi only, i-type immediate
                imm     = {{20{ins[31]}}, ins[31:20]};
                use_imm = 1'b1;
                writes  = (funct3 == 3'b000);
            end
            LUI: begin
                // u-type, upper 20 bits
                imm     = {ins[31:12], 12'b0};
                use_imm = 1'b1;
                alu_op  = PASS_B;
                is_lui  = 1'b1;
                writes  = 1'b1;
            end
            JAL: begin
                // j-type offset, bit 0 implied zero
                imm    = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                is_jal = 1'b1;
                writes = 1'b1;
            end
            JALR: begin
                imm     = {{20{ins[31]}}, ins[31:20]};
                use_imm = 1'b1;
                is_jalr = (funct3 == 3'b000);
                writes  = (funct3 == 3'b000);
            end
            default: begin
                // unsupported, falls through as a no-op
            end
        endcase

        // squashed slot does nothing
        if (!if_valid) begin
            writes  = 1'b0;
            is_jal  = 1'b0;
            is_jalr = 1'b0;
            is_lui  = 1'b0;
        end
    end

    // writes to x0 dropped here
    assign regwrite = writes & (rd != '0);

endmodule

// File: design/core/rv_execute.sv
`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_execute import rv_pkg::*; (
    input  word_t     pc,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     imm,
    input  logic      use_imm,
    input  alu_op_t   alu_op,
    input  logic      regwrite,
    input  reg_addr_t rd,
    input  logic      is_jal,
    input  logic      is_jalr,
    input  logic      is_lui,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      redirect,
    output word_t     redirect_target
);

    word_t op_b;
    word_t alu_res;
    // return address for jal/jalr
    word_t link;
    word_t jalr_sum;

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////

    assign op_b = use_imm ? imm : rs2_data;

    // lui arrives as pass_b with the u-type immediate on op_b
    always_comb begin
        case (alu_op)
            ADD:     alu_res = rs1_data + op_b;
            SUB:     alu_res = rs1_data - op_b;
            AND:     alu_res = rs1_data & op_b;
            OR:      alu_res = rs1_data | op_b;
            XOR:     alu_res = rs1_data ^ op_b;
            PASS_B:  alu_res = op_b;
            default: alu_res = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // jumps and write-back
    //////////////////////////////////////////////////

    assign link     = pc + `INSTR_BYTES;
    assign jalr_sum = rs1_data + imm;

    assign redirect        = is_jal | is_jalr;
    // jalr target has bit 0 forced low
    assign redirect_target = is_jalr ? {jalr_sum[`XLEN-1:1], 1'b0} : pc + imm;

    assign wb_en   = regwrite;
    assign wb_rd   = rd;
    assign wb_data = redirect ? link : alu_res;

    // decode flags at most one of jal, jalr and lui per slot
    always_comb begin
        a_one_kind: assert final ($onehot0({is_jal, is_jalr, is_lui}))
            else $error("slot kinds jal=%b jalr=%b lui=%b", is_jal, is_jalr, is_lui);
    end

endmodule

// File: design/core/rv_fetch.sv
`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_fetch import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  hold,
    input  logic  halt,
    input  logic  redirect,
    input  word_t redirect_target,
    output logic  imem_en,
    output word_t imem_addr,
    output word_t if_pc,
    output logic  if_valid
);

    // address currently presented to the rom
    word_t pc;

    // rom only advances when the core is running
    assign imem_en   = ~(hold | halt);
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (halt) begin
            // trapped, nothing more retires
            if_valid <= 1'b0;
        end else if (!hold) begin
            // word now leaving the rom belongs to the old pc
            if_pc    <= pc;
            // taken jump squashes the word in flight
            if_valid <= ~redirect;
            pc       <= redirect ? redirect_target : pc + `INSTR_BYTES;
        end
    end

    // jalr clears bit 0 only, so alignment rests on the program
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        imem_addr[1:0] == 2'b00
    ) else $error("imem_addr misaligned: %h", imem_addr);

endmodule

// File: design/ra_stack.sv
`timescale 1ns/1ps

`include "rv_defines.svh"

module ra_stack import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  logic  pop,
    input  word_t push_addr,
    input  word_t check_addr,
    output logic  trap,
    output logic  full,
    output logic  empty
);

    localparam int DEPTH   = `RAS_DEPTH;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    word_t mem [DEPTH];
    // next free slot, top sits one below
    logic [PTR_W-1:0]   ptr;
    logic [COUNT_W-1:0] count;
    logic [PTR_W-1:0]   ptr_inc;
    logic [PTR_W-1:0]   ptr_dec;

    // wrap explicitly, depth need not be a power of two
    assign ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    assign ptr_dec = (ptr == '0) ? PTR_W'(DEPTH - 1) : ptr - 1'b1;

    assign full  = (count == COUNT_W'(DEPTH));
    assign empty = (count == '0);

    //////////////////////////////////////////////////
    // storage, no reset
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // when full this lands on the oldest entry
        if (push) begin
            mem[ptr] <= push_addr;
        end
    end

    //////////////////////////////////////////////////
    // pointer, count and sticky trap
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr   <= '0;
            count <= '0;
            trap  <= 1'b0;
        end else if (push) begin
            ptr <= ptr_inc;
            // overflow keeps count pinned at depth
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (pop) begin
            if (empty) begin
                // return with no matching call
                trap <= 1'b1;
            end else begin
                ptr   <= ptr_dec;
                count <= count - 1'b1;
                if (mem[ptr_dec] != check_addr) begin
                    trap <= 1'b1;
                end
            end
        end
    end

    // call and return are exclusive on rd, decided at the top
    a_no_push_pop: assert property (
        @(posedge clk) disable iff (rst) !(push && pop)
    ) else $error("ra_stack push and pop together");

endmodule

// File: design/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      debug,
    input  logic      prog,
    input  reg_addr_t debug_input,
    output word_t     debug_output,
    output logic      imem_en,
    output word_t     imem_addr,
    input  word_t     imem_dout,
    output logic      ra_trap,
    output logic      stack_full,
    output logic      stack_empty
);

    // pipeline stall from either view mode
    logic      hold;
    logic      ex_valid;
    word_t     if_pc;
    logic      if_valid;

    // decode outputs
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    alu_op_t   alu_op;
    word_t     imm;
    logic      use_imm;
    logic      regwrite;
    logic      is_jal;
    logic      is_jalr;
    logic      is_lui;

    // register file and execute
    reg_addr_t rf_rs1_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      redirect;
    word_t     redirect_target;

    // stack control
    logic      push;
    logic      pop;

    assign hold     = debug | prog;
    // held slot must not retire more than once
    assign ex_valid = if_valid & ~hold;

    rv_fetch u_fetch (
        .clk(clk), .rst(rst), .hold(hold), .halt(ra_trap),
        .redirect(redirect), .redirect_target(redirect_target),
        .imem_en(imem_en), .imem_addr(imem_addr),
        .if_pc(if_pc), .if_valid(if_valid)
    );

    rv_decode u_decode (
        .ins(imem_dout), .if_valid(ex_valid),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .alu_op(alu_op), .imm(imm), .use_imm(use_imm), .regwrite(regwrite),
        .is_jal(is_jal), .is_jalr(is_jalr), .is_lui(is_lui)
    );

    // debug view borrows the rs1 read port
    assign rf_rs1_addr = debug ? debug_input : dec_rs1;

    rv_regfile u_regfile (
        .clk(clk), .rst(rst), .rs1_addr(rf_rs1_addr), .rs2_addr(dec_rs2),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_execute u_execute (
        .pc(if_pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .use_imm(use_imm), .alu_op(alu_op), .regwrite(regwrite), .rd(dec_rd),
        .is_jal(is_jal), .is_jalr(is_jalr), .is_lui(is_lui),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .redirect(redirect), .redirect_target(redirect_target)
    );

    //////////////////////////////////////////////////
    // return-address tracking
    //////////////////////////////////////////////////

    // call links a register, return links none
    assign push = (is_jal | is_jalr) & (dec_rd != '0);
    assign pop  = is_jalr & (dec_rd == '0);

    ra_stack u_ra_stack (
        .clk(clk), .rst(rst), .push(push), .pop(pop),
        .push_addr(if_pc + 32'd4), .check_addr(redirect_target),
        .trap(ra_trap), .full(stack_full), .empty(stack_empty)
    );

    // prog view wins over the register view
    always_ff @(posedge clk) begin
        if (rst) begin
            debug_output <= '0;
        end else if (prog) begin
            debug_output <= imem_dout;
        end else if (debug) begin
            debug_output <= rs1_data;
        end else begin
            debug_output <= '0;
        end
    end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            // lands at end of the execute cycle
            regs[wb_rd] <= wb_data;
        end
    end

    //////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////

    // x0 always reads zero
    // rs1 port also serves the debug view
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: run.sh
#!/bin/sh
# compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_top -o tb_top_sim

out=$(./obj_dir/tb_top_sim)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// File: tb.f
+incdir+common
common/rv_pkg.sv
design/core/rv_fetch.sv
design/core/rv_decode.sv
design/core/rv_execute.sv
design/rv_regfile.sv
design/ra_stack.sv
design/rv_core_top.sv
verification/tb_top.sv

// File: verification/tb_top.sv
`timescale 1ns/1ps

`include "rv_defines.svh"

module tb_top import rv_pkg::*; ();

    // enabled fetch edges before the program view opens
    localparam int PROG_EDGES = 6;

    logic      clk;
    logic      rst;
    logic      debug;
    logic      prog;
    reg_addr_t debug_input;
    word_t     debug_output;
    logic      imem_en;
    word_t     imem_addr;
    word_t     imem_dout = '0;
    logic      ra_trap;
    logic      stack_full;
    logic      stack_empty;

    // program image, shared by the rom model and the reference
    word_t rom [256];
    int    wp;
    integer seed;

    // reference results
    word_t exp_regs [32];
    logic  exp_trap;
    int    exp_count;
    word_t exp_pc;

    // compare channel
    event  chk_ev;
    string chk_name;
    word_t chk_got;
    word_t chk_exp;
    int    chk_count = 0;
    int    err_count = 0;
    int    tmo_count = 0;

    rv_core_top dut (
        .clk(clk), .rst(rst), .debug(debug), .prog(prog),
        .debug_input(debug_input), .debug_output(debug_output),
        .imem_en(imem_en), .imem_addr(imem_addr), .imem_dout(imem_dout),
        .ra_trap(ra_trap), .stack_full(stack_full), .stack_empty(stack_empty)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // synchronous rom, word lands one edge after the enabled address
    always @(posedge clk) begin
        if (imem_en === 1'b1) begin
            imem_dout <= rom[imem_addr[9:2]];
        end
    end

    always @(chk_ev) begin
        chk_count++;
        a_value_match: assert (chk_got === chk_exp)
        else begin
            err_count++;
            $display("CHECK FAILED %s: got %h, expected %h", chk_name, chk_got, chk_exp);
        end
    end

    //////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t addi_word(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic word_t lui_word(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, LUI};
    endfunction

    function automatic word_t jal_word(input reg_addr_t rd, input word_t off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    function automatic word_t jalr_word(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, JALR};
    endfunction

    task automatic emit(input word_t w);
        rom[wp] = w;
        wp++;
    endtask

    // pc-relative jal toward a word index
    task automatic jal_to(input reg_addr_t rd, input int idx);
        emit(jal_word(rd, word_t'((idx - wp) * 4)));
    endtask

    // lui/addi pair, upper part rounded for the signed low part
    task automatic load_const(input reg_addr_t rd, input word_t v);
        word_t hi;
        hi = (v + 32'h800) >> 12;
        emit(lui_word(rd, hi[19:0]));
        emit(addi_word(rd, rd, v[11:0]));
    endtask

    // unused words decode as no-ops, each one distinct
    task automatic clear_rom();
        for (int i = 0; i < 256; i++) begin
            rom[i] = {i[24:0], 7'b0000000};
        end
        wp = 0;
    endtask

    //////////////////////////////////////////////////
    // reference instruction-set model
    //////////////////////////////////////////////////

    function automatic void iss_run();
        word_t     pc;
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     res;
        word_t     target;
        word_t     stk [`RAS_DEPTH];
        reg_addr_t rd;
        logic      wen;
        logic      jump;
        logic      ret;
        logic      done;
        int        sp;
        int        steps;

        for (int i = 0; i < 32; i++) begin
            exp_regs[i] = '0;
        end
        pc = '0;
        sp = 0;
        exp_count = 0;
        exp_trap = 1'b0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 5000) begin
            ins = rom[pc[9:2]];
            rd = get_rd(ins);
            a = exp_regs[get_rs1(ins)];
            b = exp_regs[get_rs2(ins)];
            res = '0;
            wen = 1'b0;
            jump = 1'b0;
            ret = 1'b0;
            target = pc + 32'd4;
            case (opcode_t'(ins[6:0]))
                OP: begin
                    wen = 1'b1;
                    case ({get_funct7(ins), get_funct3(ins)})
                        {7'h00, 3'b000}: res = a + b;
                        {7'h20, 3'b000}: res = a - b;
                        {7'h00, 3'b100}: res = a ^ b;
                        {7'h00, 3'b110}: res = a | b;
                        {7'h00, 3'b111}: res = a & b;
                        default: wen = 1'b0;
                    endcase
                end
                OP_IMM: begin
                    wen = (get_funct3(ins) == 3'b000);
                    res = a + {{20{ins[31]}}, ins[31:20]};
                end
                LUI: begin
                    wen = 1'b1;
                    res = {ins[31:12], 12'b0};
                end
                JAL: begin
                    jump = 1'b1;
                    wen = 1'b1;
                    res = pc + 32'd4;
                    target = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                JALR: begin
                    if (get_funct3(ins) == 3'b000) begin
                        jump = 1'b1;
                        wen = 1'b1;
                        ret = (rd == '0);
                        res = pc + 32'd4;
                        target = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
                    end
                end
                default: begin
                    // anything else retires without effect
                end
            endcase
            // model stack, oldest entry lost on overflow
            if (jump && rd != '0) begin
                stk[sp] = pc + 32'd4;
                sp = (sp + 1) % `RAS_DEPTH;
                if (exp_count < `RAS_DEPTH) begin
                    exp_count++;
                end
            end else if (ret) begin
                if (exp_count == 0) begin
                    exp_trap = 1'b1;
                end else begin
                    sp = (sp + `RAS_DEPTH - 1) % `RAS_DEPTH;
                    exp_count--;
                    if (stk[sp] != target) begin
                        exp_trap = 1'b1;
                    end
                end
            end
            if (wen && rd != '0) begin
                exp_regs[rd] = res;
            end
            // trapped core freezes on the return target
            if (exp_trap || (jump && target == pc)) begin
                done = 1'b1;
            end
            pc = target;
            steps++;
        end
        exp_pc = pc;
        if (!done) begin
            $display("reference model ran out of steps without reaching an end");
            tmo_count++;
        end
    endfunction

    //////////////////////////////////////////////////
    // test programs
    //////////////////////////////////////////////////

    task automatic alu_program();
        word_t v;
        clear_rom();
        for (int r = 1; r <= 8; r++) begin
            v = $random(seed);
            load_const(reg_addr_t'(r), v);
        end
        emit(r_type(7'h00, 3'b000, 9, 1, 2));
        emit(r_type(7'h20, 3'b000, 10, 3, 4));
        emit(r_type(7'h00, 3'b111, 11, 5, 6));
        emit(r_type(7'h00, 3'b110, 12, 7, 8));
        emit(r_type(7'h00, 3'b100, 13, 1, 3));
        v = $random(seed);
        emit(addi_word(14, 2, v[11:0]));
        emit(lui_word(15, v[31:12]));
        // reads two results written just before
        emit(r_type(7'h00, 3'b000, 16, 9, 10));
        // writes to x0 must vanish
        emit(addi_word(0, 5, 12'h007));
        emit(r_type(7'h00, 3'b000, 0, 1, 2));
        emit(r_type(7'h20, 3'b000, 17, 0, 1));
        // ecall and a mul encoding, both no-ops here
        emit(32'h0000_0073);
        emit(r_type(7'h01, 3'b000, 18, 1, 2));
        emit(jal_word(0, '0));
    endtask

    task automatic nested_calls_program();
        clear_rom();
        emit(addi_word(5, 0, 12'd1));
        jal_to(1, 32);
        emit(addi_word(6, 0, 12'd2));
        emit(jal_word(0, '0));
        // first level, called by jal
        wp = 32;
        emit(addi_word(7, 0, 12'd3));
        emit(addi_word(2, 1, 12'd0));
        emit(addi_word(3, 0, 12'd192));
        emit(jalr_word(1, 3, 12'd0));
        emit(addi_word(8, 0, 12'd4));
        emit(jalr_word(0, 2, 12'd0));
        // second level at word 48, called through x3
        wp = 48;
        emit(addi_word(9, 0, 12'd5));
        emit(jalr_word(0, 1, 12'd0));
    endtask

    task automatic bad_return_program();
        clear_rom();
        emit(addi_word(5, 0, 12'd9));
        jal_to(1, 16);
        emit(jal_word(0, '0));
        // link register bent before the return
        wp = 16;
        emit(addi_word(1, 1, 12'd8));
        emit(jalr_word(0, 1, 12'd0));
    endtask

    // chain one deeper than the stack holds
    task automatic deep_calls_program();
        clear_rom();
        jal_to(1, 16);
        emit(jal_word(0, '0));
        for (int k = 0; k <= `RAS_DEPTH; k++) begin
            wp = 16 * (k + 1);
            if (k < `RAS_DEPTH) begin
                emit(addi_word(reg_addr_t'(10 + k), 1, 12'd0));
                jal_to(1, 16 * (k + 2));
                emit(jalr_word(0, reg_addr_t'(10 + k), 12'd0));
            end else begin
                emit(addi_word(20, 0, 12'd1));
                emit(jalr_word(0, 1, 12'd0));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // sequencing helpers
    //////////////////////////////////////////////////

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        chk_name = name;
        chk_got = got;
        chk_exp = exp;
        -> chk_ev;
        #1;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst = 1'b1;
        debug = 1'b0;
        prog = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    // end shows as the fetch address returning to the final pc
    task automatic wait_for_loop(input string label);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < 4 && cycles < 3000) begin
            @(posedge clk);
            #18;
            if (imem_addr == exp_pc) begin
                seen++;
            end
            cycles++;
        end
        if (seen < 4) begin
            tmo_count++;
            $display("%s: timed out waiting for fetch to settle at %h", label, exp_pc);
        end
    endtask

    // every register through the debug port, two cycles each
    task automatic read_back_regs(input string label);
        @(posedge clk);
        #2;
        debug = 1'b1;
        for (int i = 0; i < 32; i++) begin
            debug_input = reg_addr_t'(i);
            @(posedge clk);
            #18;
            compare_value($sformatf("%s debug_output x%0d", label, i), debug_output,
                          exp_regs[i]);
            @(posedge clk);
            #2;
        end
        debug = 1'b0;
    endtask

    task automatic wait_for_full();
        int cycles;
        cycles = 0;
        while (stack_full !== 1'b1 && cycles < 500) begin
            @(posedge clk);
            #18;
            cycles++;
        end
        if (stack_full !== 1'b1) begin
            tmo_count++;
            $display("deep: timed out waiting for stack_full");
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        seed = 32'h6df103c5;
        rst = 1'b1;
        debug = 1'b0;
        prog = 1'b0;
        debug_input = '0;

        // random alu operands, x0 writes, reset state
        alu_program();
        iss_run();
        apply_reset();
        compare_value("imem_addr", imem_addr, '0);
        compare_value("imem_en", word_t'(imem_en), 32'd1);
        compare_value("ra_trap", word_t'(ra_trap), '0);
        compare_value("debug_output", debug_output, '0);
        compare_value("stack_empty", word_t'(stack_empty), 32'd1);
        compare_value("stack_full", word_t'(stack_full), '0);
        wait_for_loop("alu");
        read_back_regs("alu");

        // two-deep calls, jal and jalr
        nested_calls_program();
        iss_run();
        apply_reset();
        wait_for_loop("nested");
        compare_value("ra_trap", word_t'(ra_trap), word_t'(exp_trap));
        compare_value("stack_empty", word_t'(stack_empty), word_t'(exp_count == 0));
        read_back_regs("nested");

        // corrupted return address
        bad_return_program();
        iss_run();
        apply_reset();
        wait_for_loop("bad return");
        compare_value("ra_trap", word_t'(ra_trap), word_t'(exp_trap));
        repeat (3) begin
            @(posedge clk);
            #18;
            compare_value("imem_addr", imem_addr, exp_pc);
            compare_value("imem_en", word_t'(imem_en), '0);
        end
        compare_value("stack_empty", word_t'(stack_empty), word_t'(exp_count == 0));
        read_back_regs("bad return");

        // overflow, then unwind into an empty stack
        deep_calls_program();
        iss_run();
        apply_reset();
        wait_for_full();
        wait_for_loop("deep");
        compare_value("ra_trap", word_t'(ra_trap), word_t'(exp_trap));
        compare_value("stack_empty", word_t'(stack_empty), word_t'(exp_count == 0));
        compare_value("stack_full", word_t'(stack_full),
                      word_t'(exp_count == `RAS_DEPTH));
        compare_value("imem_addr", imem_addr, exp_pc);
        read_back_regs("deep");

        // program view, then a debug hold, both mid-run
        alu_program();
        iss_run();
        apply_reset();
        repeat (PROG_EDGES) @(posedge clk);
        #2;
        prog = 1'b1;
        // straight-line start, last enabled edge fetched word PROG_EDGES-1
        repeat (3) begin
            @(posedge clk);
            #18;
            compare_value("debug_output", debug_output, rom[PROG_EDGES - 1]);
        end
        @(posedge clk);
        #2;
        prog = 1'b0;
        @(posedge clk);
        #18;
        compare_value("debug_output", debug_output, '0);
        repeat (3) @(posedge clk);
        #2;
        debug = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        debug = 1'b0;
        wait_for_loop("hold");
        read_back_regs("hold");

        $display("checks %0d, errors %0d, timeouts %0d", chk_count, err_count, tmo_count);
        if (err_count == 0 && tmo_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
